// ==== common/rf_cfg_pkg.sv ====
// register file configuration
// geometry of the register array, the index and value types,
// and which read port belongs to the host

`default_nettype none

package rf_cfg_pkg;

    //////////////////////////////////////////////////
    // geometry

    localparam int rf_addr_width = 4;
    localparam int rf_data_width = 32;
    localparam int rf_registers  = 1 << rf_addr_width;  // 16 entries

    //////////////////////////////////////////////////
    // types

    typedef logic [rf_addr_width-1:0] rf_addr_t;  // register index
    typedef logic [rf_data_width-1:0] rf_data_t;  // register value

    // ports 0 and 1 feed the ALU sources
    localparam int rf_host_read_port = 2;

endpackage

`default_nettype wire

// ==== common/alu_op_pkg.sv ====
// ALU operation encoding
// 3-bit opcode shared by the top level and the execution pipeline

`default_nettype none

package alu_op_pkg;

    localparam int alu_op_width    = 3;
    localparam int alu_shamt_width = 5;  // low bits of rs2 used as shift count

    //////////////////////////////////////////////////
    // operation codes

    typedef enum logic [alu_op_width-1:0] {
        op_add  = 3'd0,
        op_sub  = 3'd1,
        op_and  = 3'd2,
        op_or   = 3'd3,
        op_xor  = 3'd4,
        op_sll  = 3'd5,  // shift left logical
        op_srl  = 3'd6,  // shift right logical
        op_sltu = 3'd7   // set if rs1 < rs2, unsigned
    } alu_op_t;

endpackage

`default_nettype wire

// ==== regfile/register_file.sv ====
// register file
// one write port, several registered read ports
// reads see a write in the same cycle, register 0 optionally tied to zero

`timescale 1ns/100ps
`default_nettype none

module register_file #(
    parameter int read_ports = 2,
    parameter bit zero_reg   = 1'b1
) (
    input  wire                                         clk,
    input  wire                                         reset,

    // write port
    input  wire                                         wr_en,
    input  wire rf_cfg_pkg::rf_addr_t                   wr_addr,
    input  wire rf_cfg_pkg::rf_data_t                   wr_din,

    // read ports
    input  wire [read_ports-1:0]                        rd_en,
    input  wire rf_cfg_pkg::rf_addr_t [read_ports-1:0]  rd_addr,
    output rf_cfg_pkg::rf_data_t [read_ports-1:0]       rd_dout
);
    import rf_cfg_pkg::*;

    rf_data_t [rf_registers-1:0] regs;       // stored contents
    rf_data_t [rf_registers-1:0] regs_wr;    // contents with this cycle's write applied
    rf_data_t [rf_registers-1:0] regs_next;  // what gets stored at the edge

    //////////////////////////////////////////////////
    // write first, then zero register

    always_comb begin
        regs_wr = regs;
        if (wr_en) begin
            regs_wr[wr_addr] = wr_din;
        end

        // reads below use regs_wr, so a write to r0 is still visible this cycle
        regs_next = regs_wr;
        if (zero_reg) begin
            regs_next[0] = '0;
        end
    end

    //////////////////////////////////////////////////
    // array and read outputs

    always_ff @(posedge clk) begin
        if (reset) begin
            regs    <= '0;
            rd_dout <= '0;
        end else begin
            regs <= regs_next;
            for (int i = 0; i < read_ports; i++) begin
                if (rd_en[i]) begin
                    rd_dout[i] <= regs_wr[rd_addr[i]];  // idle port holds its value
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== regfile/write_arbiter.sv ====
// write port arbiter
// fixed priority between the ALU write-back and the host
// the ALU always wins since the pipeline cannot stall

`timescale 1ns/100ps
`default_nettype none

module write_arbiter (
    // ALU write-back
    input  wire                        alu_wr_en,
    input  wire rf_cfg_pkg::rf_addr_t  alu_wr_addr,
    input  wire rf_cfg_pkg::rf_data_t  alu_wr_data,

    // host request
    input  wire                        host_wr_req,
    input  wire rf_cfg_pkg::rf_addr_t  host_wr_addr,
    input  wire rf_cfg_pkg::rf_data_t  host_wr_data,

    // register file write port
    output logic                       wr_en,
    output rf_cfg_pkg::rf_addr_t       wr_addr,
    output rf_cfg_pkg::rf_data_t       wr_data,
    output logic                       host_grant
);

    // host only gets the port when the ALU is idle
    assign host_grant = host_wr_req && !alu_wr_en;

    assign wr_en   = alu_wr_en || host_wr_req;
    assign wr_addr = alu_wr_en ? alu_wr_addr : host_wr_addr;
    assign wr_data = alu_wr_en ? alu_wr_data : host_wr_data;

endmodule

`default_nettype wire

// ==== design/alu_exec.sv ====
// ALU execution pipeline
// issue reads two sources, stage ex computes, stage wb writes back
// issue to result_valid is two cycles, two ops may be in flight

`timescale 1ns/100ps
`default_nettype none

module alu_exec (
    input  wire                        clk,
    input  wire                        reset,

    // issue
    input  wire                        issue,
    input  wire alu_op_pkg::alu_op_t   op,
    input  wire rf_cfg_pkg::rf_addr_t  rd,
    input  wire rf_cfg_pkg::rf_addr_t  rs1,
    input  wire rf_cfg_pkg::rf_addr_t  rs2,

    // source reads, ports 0 and 1
    output logic [1:0]                 rd_en,
    output rf_cfg_pkg::rf_addr_t       rd_addr0,
    output rf_cfg_pkg::rf_addr_t       rd_addr1,
    input  wire rf_cfg_pkg::rf_data_t  rs1_data,
    input  wire rf_cfg_pkg::rf_data_t  rs2_data,

    // write-back and result
    output logic                       alu_wr_en,
    output rf_cfg_pkg::rf_addr_t       alu_wr_addr,
    output rf_cfg_pkg::rf_data_t       alu_wr_data,
    output logic                       result_valid,
    output rf_cfg_pkg::rf_data_t       result
);
    import rf_cfg_pkg::*;
    import alu_op_pkg::*;

    logic                       ex_valid;
    alu_op_t                    ex_op;
    rf_addr_t                   ex_rd;
    rf_data_t                   ex_result;
    logic [alu_shamt_width-1:0] shamt;
    logic                       wb_valid;
    rf_addr_t                   wb_rd;
    rf_data_t                   wb_result;

    // cycle 0: sources go straight to the register file
    assign rd_en    = {2{issue}};
    assign rd_addr0 = rs1;
    assign rd_addr1 = rs2;

    always_ff @(posedge clk) begin
        if (reset) begin
            ex_valid <= 1'b0;
            wb_valid <= 1'b0;
        end else begin
            ex_valid <= issue;
            wb_valid <= ex_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (issue) begin
            ex_op <= op;
            ex_rd <= rd;
        end
        if (ex_valid) begin
            wb_rd     <= ex_rd;
            wb_result <= ex_result;
        end
    end

    //////////////////////////////////////////////////
    // cycle 1: compute on the registered sources

    assign shamt = rs2_data[alu_shamt_width-1:0];

    always_comb begin
        case (ex_op)
            op_add:  ex_result = rs1_data + rs2_data;
            op_sub:  ex_result = rs1_data - rs2_data;
            op_and:  ex_result = rs1_data & rs2_data;
            op_or:   ex_result = rs1_data | rs2_data;
            op_xor:  ex_result = rs1_data ^ rs2_data;
            op_sll:  ex_result = rs1_data << shamt;
            op_srl:  ex_result = rs1_data >> shamt;
            op_sltu: ex_result = {{(rf_data_width-1){1'b0}}, rs1_data < rs2_data};
            default: ex_result = '0;
        endcase
    end

    // cycle 2: write-back
    assign alu_wr_en    = wb_valid;
    assign alu_wr_addr  = wb_rd;
    assign alu_wr_data  = wb_result;
    assign result_valid = wb_valid;
    assign result       = wb_result;

    issue_to_result: assert property (@(posedge clk) disable iff (reset)
        issue |-> ##2 result_valid);
    result_from_issue: assert property (@(posedge clk) disable iff (reset)
        result_valid |-> $past(issue, 2));

endmodule

`default_nettype wire

// ==== design/host_access.sv ====
// host access port
// host writes go through the arbiter, a denied write waits in a
// one-entry holding register with busy raised, reads use a spare port

`timescale 1ns/100ps
`default_nettype none

module host_access (
    input  wire                        clk,
    input  wire                        reset,

    // host write side
    input  wire                        host_wr,
    input  wire rf_cfg_pkg::rf_addr_t  host_wr_addr,
    input  wire rf_cfg_pkg::rf_data_t  host_wr_data,
    input  wire                        host_grant,
    output logic                       host_wr_req,
    output rf_cfg_pkg::rf_addr_t       req_addr,
    output rf_cfg_pkg::rf_data_t       req_data,
    output logic                       host_busy,

    // host read side
    input  wire                        host_rd,
    input  wire rf_cfg_pkg::rf_addr_t  host_rd_addr,
    output logic                       rd_en,
    output rf_cfg_pkg::rf_addr_t       rd_addr,
    input  wire rf_cfg_pkg::rf_data_t  rd_dout,
    output logic                       host_rd_valid,
    output rf_cfg_pkg::rf_data_t       host_rd_data
);
    import rf_cfg_pkg::*;

    rf_addr_t hold_addr;
    rf_data_t hold_data;

    //////////////////////////////////////////////////
    // write request

    assign host_wr_req = host_wr || host_busy;
    assign req_addr    = host_busy ? hold_addr : host_wr_addr;  // held entry first
    assign req_data    = host_busy ? hold_data : host_wr_data;

    always_ff @(posedge clk) begin
        if (reset) begin
            host_busy     <= 1'b0;
            host_rd_valid <= 1'b0;
        end else begin
            host_busy     <= host_wr_req && !host_grant;  // stays up until granted
            host_rd_valid <= host_rd;
        end
    end

    always_ff @(posedge clk) begin
        if (host_wr && !host_busy) begin
            hold_addr <= host_wr_addr;
            hold_data <= host_wr_data;
        end
    end

    // read: data comes back registered from the register file
    assign rd_en        = host_rd;
    assign rd_addr      = host_rd_addr;
    assign host_rd_data = rd_dout;

    no_wr_while_busy: assert property (@(posedge clk) disable iff (reset)
        host_busy |-> !host_wr);

endmodule

`default_nettype wire

// ==== design/rf_exec_top.sv ====
// register file execution unit
// ALU pipeline and host port sharing a 3-read, 1-write register file

`timescale 1ns/100ps
`default_nettype none

module rf_exec_top (
    input  wire                        clk,
    input  wire                        reset,

    // ALU issue
    input  wire                        issue,
    input  wire alu_op_pkg::alu_op_t   op,
    input  wire rf_cfg_pkg::rf_addr_t  rd,
    input  wire rf_cfg_pkg::rf_addr_t  rs1,
    input  wire rf_cfg_pkg::rf_addr_t  rs2,
    output wire                        result_valid,
    output wire rf_cfg_pkg::rf_data_t  result,

    // host write
    input  wire                        host_wr,
    input  wire rf_cfg_pkg::rf_addr_t  host_wr_addr,
    input  wire rf_cfg_pkg::rf_data_t  host_wr_data,
    output wire                        host_busy,

    // host read
    input  wire                        host_rd,
    input  wire rf_cfg_pkg::rf_addr_t  host_rd_addr,
    output wire                        host_rd_valid,
    output wire rf_cfg_pkg::rf_data_t  host_rd_data
);
    import rf_cfg_pkg::*;

    localparam int read_ports = rf_host_read_port + 1;

    logic [read_ports-1:0]     rf_rd_en;
    rf_addr_t [read_ports-1:0] rf_rd_addr;
    rf_data_t [read_ports-1:0] rf_rd_dout;
    logic                      wr_en;
    rf_addr_t                  wr_addr;
    rf_data_t                  wr_data;
    logic                      alu_wr_en;
    rf_addr_t                  alu_wr_addr;
    rf_data_t                  alu_wr_data;
    logic                      host_wr_req;
    logic                      host_grant;
    rf_addr_t                  req_addr;
    rf_data_t                  req_data;

    register_file #(
        .read_ports (read_ports),
        .zero_reg   (1'b1)
    ) register_file_inst (
        .clk     (clk),
        .reset   (reset),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_din  (wr_data),
        .rd_en   (rf_rd_en),
        .rd_addr (rf_rd_addr),
        .rd_dout (rf_rd_dout)
    );

    write_arbiter write_arbiter_inst (
        .alu_wr_en    (alu_wr_en),
        .alu_wr_addr  (alu_wr_addr),
        .alu_wr_data  (alu_wr_data),
        .host_wr_req  (host_wr_req),
        .host_wr_addr (req_addr),
        .host_wr_data (req_data),
        .wr_en        (wr_en),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .host_grant   (host_grant)
    );

    // ALU owns read ports 0 and 1
    alu_exec alu_exec_inst (
        .clk          (clk),
        .reset        (reset),
        .issue        (issue),
        .op           (op),
        .rd           (rd),
        .rs1          (rs1),
        .rs2          (rs2),
        .rd_en        (rf_rd_en[1:0]),
        .rd_addr0     (rf_rd_addr[0]),
        .rd_addr1     (rf_rd_addr[1]),
        .rs1_data     (rf_rd_dout[0]),
        .rs2_data     (rf_rd_dout[1]),
        .alu_wr_en    (alu_wr_en),
        .alu_wr_addr  (alu_wr_addr),
        .alu_wr_data  (alu_wr_data),
        .result_valid (result_valid),
        .result       (result)
    );

    host_access host_access_inst (
        .clk           (clk),
        .reset         (reset),
        .host_wr       (host_wr),
        .host_wr_addr  (host_wr_addr),
        .host_wr_data  (host_wr_data),
        .host_grant    (host_grant),
        .host_wr_req   (host_wr_req),
        .req_addr      (req_addr),
        .req_data      (req_data),
        .host_busy     (host_busy),
        .host_rd       (host_rd),
        .host_rd_addr  (host_rd_addr),
        .rd_en         (rf_rd_en[rf_host_read_port]),
        .rd_addr       (rf_rd_addr[rf_host_read_port]),
        .rd_dout       (rf_rd_dout[rf_host_read_port]),
        .host_rd_valid (host_rd_valid),
        .host_rd_data  (host_rd_data)
    );

endmodule

`default_nettype wire

// ==== dv/rf_exec_tb.sv ====
// testbench for the register file execution unit
// directed tests against a register model, LFSR data and a watchdog

`timescale 1ns/100ps
`default_nettype none

module rf_exec_tb;
    import rf_cfg_pkg::*;
    import alu_op_pkg::*;

    localparam int reset_cycles = 8;
    localparam int test_ops     = 120;  // rough count of host and ALU operations

    logic     clk;
    logic     reset;
    logic     issue;
    alu_op_t  op;
    rf_addr_t rd;
    rf_addr_t rs1;
    rf_addr_t rs2;
    logic     result_valid;
    rf_data_t result;
    logic     host_wr;
    rf_addr_t host_wr_addr;
    rf_data_t host_wr_data;
    logic     host_busy;
    logic     host_rd;
    rf_addr_t host_rd_addr;
    logic     host_rd_valid;
    rf_data_t host_rd_data;

    rf_data_t    model [rf_registers];  // expected register contents
    logic [31:0] lfsr_state;

    rf_exec_top rf_exec_top_inst (
        .clk           (clk),
        .reset         (reset),
        .issue         (issue),
        .op            (op),
        .rd            (rd),
        .rs1           (rs1),
        .rs2           (rs2),
        .result_valid  (result_valid),
        .result        (result),
        .host_wr       (host_wr),
        .host_wr_addr  (host_wr_addr),
        .host_wr_data  (host_wr_data),
        .host_busy     (host_busy),
        .host_rd       (host_rd),
        .host_rd_addr  (host_rd_addr),
        .host_rd_valid (host_rd_valid),
        .host_rd_data  (host_rd_data)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (reset_cycles + test_ops * 20) @(posedge clk);
        $display("watchdog expired before the tests finished");
        $display("FAIL: see errors above");
        $fatal(1);
    end

    //////////////////////////////////////////////////
    // helpers

    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};  // x^32 + x^22 + x^2 + x + 1
    endfunction

    task automatic rand_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            val        = {val[30:0], lfsr_state[0]};
        end
    endtask

    // operation rules, straight from the opcode table
    function automatic rf_data_t alu_ref(input alu_op_t f, input rf_data_t a, input rf_data_t b);
        case (f)
            op_add:  return a + b;
            op_sub:  return a - b;
            op_and:  return a & b;
            op_or:   return a | b;
            op_xor:  return a ^ b;
            op_sll:  return a << b[4:0];
            op_srl:  return a >> b[4:0];
            op_sltu: return (a < b) ? 32'd1 : 32'd0;
            default: return '0;
        endcase
    endfunction

    task automatic check_equal(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("ERR %s: got %h, expected %h", name, actual, expected);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic host_write(input rf_addr_t addr, input rf_data_t data);
        host_wr      = 1'b1;
        host_wr_addr = addr;
        host_wr_data = data;
        @(negedge clk);
        host_wr = 1'b0;
        check_equal("host_busy", 32'(host_busy), 32'd0);  // ALU idle, granted at once
        model[addr] = data;
        model[0]    = '0;
    endtask

    task automatic write_random(input rf_addr_t addr);
        rf_data_t v;
        rand_bits(32, v);
        host_write(addr, v);
    endtask

    task automatic host_read_check(input rf_addr_t addr, input rf_data_t expected);
        host_rd      = 1'b1;
        host_rd_addr = addr;
        @(negedge clk);
        host_rd = 1'b0;
        check_equal("host_rd_valid", 32'(host_rd_valid), 32'd1);
        check_equal("host_rd_data", host_rd_data, expected);
    endtask

    task automatic drive_issue(input alu_op_t f, input rf_addr_t d, input rf_addr_t s1,
                               input rf_addr_t s2);
        issue = 1'b1;
        op    = f;
        rd    = d;
        rs1   = s1;
        rs2   = s2;
    endtask

    task automatic expect_result(input rf_data_t expected);
        check_equal("result_valid", 32'(result_valid), 32'd1);
        check_equal("result", result, expected);
    endtask

    // single op, result exactly two cycles after issue
    task automatic run_op(input alu_op_t f, input rf_addr_t d, input rf_addr_t s1,
                          input rf_addr_t s2);
        rf_data_t expected;
        expected = alu_ref(f, model[s1], model[s2]);
        drive_issue(f, d, s1, s2);
        @(negedge clk);
        issue = 1'b0;
        check_equal("result_valid", 32'(result_valid), 32'd0);
        @(negedge clk);
        expect_result(expected);
        @(negedge clk);
        model[d] = expected;
        model[0] = '0;
    endtask

    //////////////////////////////////////////////////
    // tests

    task automatic test_reset_and_host();
        check_equal("result_valid", 32'(result_valid), 32'd0);
        check_equal("host_busy", 32'(host_busy), 32'd0);
        check_equal("host_rd_valid", 32'(host_rd_valid), 32'd0);
        for (int i = 0; i < rf_registers; i++) begin
            host_read_check(rf_addr_t'(i), '0);
        end
        for (int i = 1; i < rf_registers; i++) begin
            write_random(rf_addr_t'(i));
            host_read_check(rf_addr_t'(i), model[i]);
        end
    endtask

    task automatic test_alu_ops();
        for (int i = 0; i < 8; i++) begin
            write_random(4'd1);
            write_random(4'd2);
            run_op(alu_op_t'(i[2:0]), 4'd3, 4'd1, 4'd2);
            host_read_check(4'd3, model[3]);  // write-back landed
        end
    endtask

    task automatic test_pipeline();
        logic [31:0] bits;
        alu_op_t     op_a;
        alu_op_t     op_b;
        rf_data_t    exp_a;
        rf_data_t    exp_b;
        rf_data_t    exp_c1;
        rf_data_t    exp_c2;
        for (int n = 0; n < 4; n++) begin
            write_random(4'd2);
            write_random(4'd3);
            write_random(4'd5);
            write_random(4'd6);
            rand_bits(3, bits);
            op_a = alu_op_t'(bits[2:0]);
            rand_bits(3, bits);
            op_b  = alu_op_t'(bits[2:0]);
            exp_a = alu_ref(op_a, model[2], model[3]);
            exp_b = alu_ref(op_b, model[5], model[6]);
            drive_issue(op_a, 4'd1, 4'd2, 4'd3);
            @(negedge clk);
            drive_issue(op_b, 4'd4, 4'd5, 4'd6);  // two in flight
            @(negedge clk);
            issue = 1'b0;
            expect_result(exp_a);
            model[1] = exp_a;
            @(negedge clk);
            expect_result(exp_b);
            model[4] = exp_b;
            @(negedge clk);
        end

        // producer r7, then consumers one and two cycles later
        write_random(4'd8);
        write_random(4'd9);
        write_random(4'd12);
        exp_a  = alu_ref(op_add, model[8], model[9]);
        exp_c1 = alu_ref(op_xor, model[7], model[12]);  // old r7
        exp_c2 = alu_ref(op_sub, exp_a, model[12]);     // new r7, write-first
        drive_issue(op_add, 4'd7, 4'd8, 4'd9);
        @(negedge clk);
        drive_issue(op_xor, 4'd10, 4'd7, 4'd12);
        @(negedge clk);
        drive_issue(op_sub, 4'd11, 4'd7, 4'd12);
        expect_result(exp_a);
        @(negedge clk);
        issue = 1'b0;
        expect_result(exp_c1);
        @(negedge clk);
        expect_result(exp_c2);
        @(negedge clk);
        model[7]  = exp_a;
        model[10] = exp_c1;
        model[11] = exp_c2;
        host_read_check(4'd7, model[7]);
        host_read_check(4'd11, model[11]);
    endtask

    task automatic test_zero_reg();
        rf_data_t expected;
        write_random(4'd1);
        write_random(4'd2);
        expected = alu_ref(op_add, model[1], model[2]);
        drive_issue(op_add, 4'd0, 4'd1, 4'd2);
        @(negedge clk);
        issue = 1'b0;
        @(negedge clk);
        expect_result(expected);
        host_read_check(4'd0, expected);  // read in the write-back cycle
        host_read_check(4'd0, '0);
        run_op(op_or, 4'd3, 4'd0, 4'd2);
        host_read_check(4'd3, model[2]);  // r0 read as zero
    endtask

    task automatic test_arbitration();
        rf_data_t expected;
        rf_data_t host_data;
        rf_addr_t host_addr;
        for (int n = 0; n < 2; n++) begin
            host_addr = (n == 0) ? 4'd5 : 4'd13;  // second round hits the ALU destination
            write_random(4'd14);
            write_random(4'd15);
            rand_bits(32, host_data);
            expected = alu_ref(op_add, model[14], model[15]);
            drive_issue(op_add, 4'd13, 4'd14, 4'd15);
            @(negedge clk);
            issue = 1'b0;
            @(negedge clk);
            expect_result(expected);
            host_wr      = 1'b1;  // collides with the ALU write-back
            host_wr_addr = host_addr;
            host_wr_data = host_data;
            @(negedge clk);
            host_wr = 1'b0;
            check_equal("host_busy", 32'(host_busy), 32'd1);
            @(negedge clk);
            check_equal("host_busy", 32'(host_busy), 32'd0);
            model[13]        = expected;
            model[host_addr] = host_data;  // host lands after the ALU
            host_read_check(4'd5, model[5]);
            host_read_check(4'd13, model[13]);
        end
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial begin
        lfsr_state   = 32'h3fff;
        reset        = 1'b1;
        issue        = 1'b0;
        op           = op_add;
        rd           = '0;
        rs1          = '0;
        rs2          = '0;
        host_wr      = 1'b0;
        host_wr_addr = '0;
        host_wr_data = '0;
        host_rd      = 1'b0;
        host_rd_addr = '0;
        for (int i = 0; i < rf_registers; i++) begin
            model[i] = '0;
        end
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;

        test_reset_and_host();
        test_alu_ops();
        test_pipeline();
        test_zero_reg();
        test_arbitration();

        $display("PASS: all tests");
        $finish;
    end

endmodule

`default_nettype wire

// ==== project.f ====
common/rf_cfg_pkg.sv
common/alu_op_pkg.sv
regfile/register_file.sv
regfile/write_arbiter.sv
design/alu_exec.sv
design/host_access.sv
design/rf_exec_top.sv
dv/rf_exec_tb.sv

// ==== Makefile ====
# Verilator build for the register file execution unit
# override any variable on the command line, e.g. make sim TOP=rf_exec_tb

VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= rf_exec_tb
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_ARGS  ?=

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS)

clean:
	rm -rf $(BUILD_DIR)
